// ==== sources.f ====
verilog/up_pkg.sv
verilog/up_control.sv
verilog/up_datapath.sv
verilog/up_memory.sv
verilog/up_core.sv
dv/up_core_sva.sv
dv/up_core_tb.sv

// ==== Makefile ====
# Verilator flow for the up_core testbench

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module up_core_tb -f sources.f

sim:
	verilator --binary --timing --assert --top-module up_core_tb -f sources.f -o up_core_tb
	./obj_dir/up_core_tb | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/up_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module up_core_tb
   import up_pkg::*;
();

   localparam int timeout_cycles = 3000;                       // Sweep ~800, programs ~60 each
   localparam int start_cycles   = 7;                          // Restart pulse and load steps
   localparam int short_cycles   = 3;
   localparam int mem_cycles     = 4;
   localparam int swap_cycles    = 5;

   logic                   clk;
   logic                   nRst;
   logic                   mem_map_load;
   logic [host_addr_w-1:0] mem_map_address;
   logic [data_w-1:0]      mem_map_in;
   logic [data_w-1:0]      mem_map_out;
   integer                 seed;
   int                     cycle_count;

   up_core i_up_core (.clk, .nRst, .mem_map_load, .mem_map_address, .mem_map_in, .mem_map_out);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < timeout_cycles) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Checks failed");
      $fatal(1, "Run still busy after %0d cycles", timeout_cycles);
   end

   function automatic logic [data_w-1:0] fill_pattern(input logic [data_w-1:0] a);
      return {a[2:0], a[7:3]} ^ 8'h5c;
   endfunction

   function automatic logic [data_w-1:0] alu_result(input opcode_t op,
                                                    input logic [data_w-1:0] x,
                                                    input logic [data_w-1:0] y);
      logic [2*data_w-1:0] full;
      full = {8'h00, x} * {8'h00, y};
      case (op)
         op_add:  return x + y;
         op_sub:  return x - y;
         op_mul:  return full[data_w-1:0];                     // Low byte kept
         default: return ~(x & y);
      endcase
   endfunction

   task automatic check_byte(input string name, input logic [data_w-1:0] actual,
                             input logic [data_w-1:0] expected);
      if (actual !== expected) begin
         $display("** Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
         $display("Checks failed");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   task automatic check_state(input string name, input state_t actual, input state_t expected);
      if (actual !== expected) begin
         $display("** Error at %0t: %s is %s, expected %s", $time, name, actual.name(),
                  expected.name());
         $display("Checks failed");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   task automatic write_byte(input logic [host_addr_w-1:0] a, input logic [data_w-1:0] d);
      @(negedge clk);
      mem_map_load    = 1'b1;
      mem_map_address = a;
      mem_map_in      = d;
      @(negedge clk);
      mem_map_load = 1'b0;
   endtask

   task automatic read_byte(input logic [host_addr_w-1:0] a, output logic [data_w-1:0] d);
      @(negedge clk);
      mem_map_address = a;
      #1;
      d = mem_map_out;                                         // Halted, so stable
   endtask

   task automatic run_core();
      write_byte(host_ctrl_addr, 8'h01);
   endtask

   task automatic halt_core();
      write_byte(host_ctrl_addr, 8'h00);
   endtask

   task automatic check_registers(input logic [data_w-1:0] e0, input logic [data_w-1:0] e1,
                                  input logic [data_w-1:0] e2, input logic [data_w-1:0] e3);
      logic [data_w-1:0] v;
      read_byte({1'b1, host_r0_addr}, v);
      check_byte("r0", v, e0);
      read_byte({1'b1, host_r0_addr + 8'd1}, v);
      check_byte("r1", v, e1);
      read_byte({1'b1, host_r0_addr + 8'd2}, v);
      check_byte("r2", v, e2);
      read_byte({1'b1, host_r0_addr + 8'd3}, v);
      check_byte("r3", v, e3);
   endtask

   // Bytes 0 to 3, six program nibbles, then reserved padding
   task automatic load_image(input logic [data_w-1:0] b0, input logic [data_w-1:0] b1,
                             input logic [data_w-1:0] b2, input logic [data_w-1:0] b3,
                             input logic [23:0] prog);
      halt_core();
      write_byte(9'h000, b0);
      write_byte(9'h001, b1);
      write_byte(9'h002, b2);
      write_byte(9'h003, b3);
      write_byte(9'h004, prog[23:16]);
      write_byte(9'h005, prog[15:8]);
      write_byte(9'h006, prog[7:0]);
      write_byte(9'h007, 8'h88);
      write_byte(9'h008, 8'h88);
      write_byte(9'h009, 8'h88);
   endtask

   task automatic run_for(input int cycles);
      run_core();
      repeat (cycles) @(negedge clk);
      halt_core();
   endtask

   task automatic reset_and_memory_sweep();
      logic [data_w-1:0] v;
      int                a;
      read_byte({1'b1, host_state_addr}, v);
      check_state("state", state_t'(v[3:0]), st_halt);
      read_byte({1'b1, host_pc_addr}, v);
      check_byte("pc", v, pc_reset);
      check_registers(8'h00, 8'h00, 8'h00, 8'h00);
      for (a = 0; a < mem_depth; a++) write_byte(host_addr_w'(a), fill_pattern(8'(a)));
      for (a = 0; a < mem_depth; a++) begin
         read_byte(host_addr_w'(a), v);
         check_byte($sformatf("mem[%0d]", a), v, fill_pattern(8'(a)));
      end
   endtask

   task automatic start_sequence_loads();
      logic [data_w-1:0] b0, b1, b2, b3;
      b0 = 8'($random(seed));
      b1 = 8'($random(seed));
      b2 = 8'($random(seed));
      b3 = 8'($random(seed));
      load_image(b0, b1, b2, b3, 24'h888888);
      run_for(start_cycles);
      check_registers(b0, b1, b2, b3);
   endtask

   task automatic alu_ops_into_r0();
      logic [data_w-1:0] x, y, c0;
      opcode_t           op;
      int                i;
      c0 = 8'($random(seed));
      x  = 8'($random(seed));
      y  = 8'($random(seed));
      for (i = 0; i < 4; i++) begin
         op = opcode_t'(i);                                    // ADD, SUB, MUL, NAND
         load_image(c0, x, y, 8'h20, {op, 20'h88888});
         run_for(start_cycles + short_cycles);
         check_registers(alu_result(op, x, y), x, y, 8'h20);
      end
   endtask

   task automatic register_swaps();
      logic [data_w-1:0] b0, b1, b2, b3;
      b0 = 8'($random(seed));
      b1 = 8'($random(seed));
      b2 = 8'($random(seed));
      b3 = 8'($random(seed));
      load_image(b0, b1, b2, b3, {op_sw01, 20'h88888});
      run_for(start_cycles + swap_cycles);
      check_registers(b1, b0, b2, b3);
      load_image(b0, b1, b2, b3, {op_sw12, 20'h88888});
      run_for(start_cycles + swap_cycles);
      check_registers(b0, b2, b1, b3);
      load_image(b0, b1, b2, b3, {op_sw23, 20'h88888});
      run_for(start_cycles + swap_cycles);
      check_registers(b0, b1, b3, b2);
   endtask

   task automatic memory_ops_through_r3();
      logic [data_w-1:0] b0, b1, b2, w, v;
      b0 = 8'($random(seed));
      b1 = 8'($random(seed));
      b2 = 8'($random(seed));
      w  = 8'($random(seed));
      // ADD spoils r0 so REF has something to restore
      load_image(b0, b1, b2, 8'h20, {op_add, op_stw, op_ref, 12'h888});
      run_for(start_cycles + short_cycles + 2 * mem_cycles);
      check_registers(b0, b1, b2, 8'h20);
      read_byte(9'h020, v);
      check_byte("mem[32]", v, b2);
      load_image(b0, b1, b2, 8'h20, {op_ldw, 20'h88888});
      write_byte(9'h020, w);
      run_for(start_cycles + mem_cycles);
      check_registers(b0, b1, w, 8'h20);
   endtask

   task automatic branch_and_reserved();
      logic [data_w-1:0] v;
      load_image(8'h5a, 8'h21, 8'h34, 8'h10, {op_be, op_rsv8, op_ldw, op_be, 8'h00});
      write_byte(9'h007, 8'h00);                               // ADDs catch a missed branch
      write_byte(9'h008, 8'h78);                               // BE to itself at nibble 16
      write_byte(9'h010, 8'h21);
      run_for(start_cycles + 3 * short_cycles + mem_cycles);
      check_registers(8'h5a, 8'h21, 8'h21, 8'h10);
      read_byte({1'b1, host_ir_addr}, v);
      check_byte("ir", v, 8'h07);
      read_byte({1'b1, host_pc_addr}, v);
      if (v !== 8'h10 && v !== 8'h11) begin
         $display("** Error at %0t: pc is %h, expected 10 or 11", $time, v);
         $display("Checks failed");
         $fatal(1, "Branch did not settle in its loop");
      end
   endtask

   initial begin
      seed            = 32'h78887a53;
      nRst            = 1'b0;
      mem_map_load    = 1'b0;
      mem_map_address = '0;
      mem_map_in      = '0;
      repeat (10) @(negedge clk);
      nRst = 1'b1;
      reset_and_memory_sweep();
      start_sequence_loads();
      alu_ops_into_r0();
      register_swaps();
      memory_ops_through_r3();
      branch_and_reserved();
      if (i_up_core.i_up_control.i_up_control_sva.fail_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/up_core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module up_control_sva
   import up_pkg::*;
(
   input wire logic       clk,
   input wire logic       nRst,
   input wire logic [3:0] state,
   input wire logic       ir_we,
   input wire logic       pc_we,
   input wire logic       rb_we,
   input wire logic       ale,
   input wire logic       mem_we
);

   logic any_we;
   int   fail_count = 0;                                        // Read by the testbench at the end

   assign any_we = ir_we | pc_we | rb_we | ale | mem_we;

   no_store_with_ale: assert property (@(posedge clk) disable iff (!nRst) !(mem_we && ale))
      else begin
         fail_count++;
         $error("mem_we and ale high in the same cycle");
      end

   state_encoding: assert property (@(posedge clk) disable iff (!nRst)
      state <= 4'(st_exec_3))
      else begin
         fail_count++;
         $error("state holds unused encoding %h", state);
      end

   halt_quiet: assert property (@(posedge clk) disable iff (!nRst)
      (state == 4'(st_halt)) |-> !any_we)
      else begin
         fail_count++;
         $error("enable active while halted");
      end

endmodule

bind up_control up_control_sva i_up_control_sva (
   .clk(clk), .nRst(nRst), .state(state),
   .ir_we(ir_we), .pc_we(pc_we), .rb_we(rb_we), .ale(ale), .mem_we(mem_we)
);

`default_nettype wire

// ==== verilog/up_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module up_core
   import up_pkg::*;
(
   input  wire logic                   clk,
   input  wire logic                   nRst,
   input  wire logic                   mem_map_load,
   input  wire logic [host_addr_w-1:0] mem_map_address,
   input  wire logic [data_w-1:0]      mem_map_in,
   output logic      [data_w-1:0]      mem_map_out
);

   state_t              state;
   bus_src_t            bus_src;
   reg_sel_t            rb_sel;
   opcode_t             opcode;
   logic [data_w-1:0]   bus_const;
   logic [data_w-1:0]   data_bus;
   logic [data_w-1:0]   data_in;
   logic [data_w-1:0]   addr;
   logic [data_w-1:0]   pc;
   logic [3:0]          ir;
   logic [data_w-1:0]   r0, r1, r2, r3;
   logic                ir_we, pc_we, rb_we, rb_from_mem, ale, mem_we;
   logic                regs_equal;
   logic                restart, halt;

   up_control i_up_control (
      .clk, .nRst,
      .restart, .halt,
      .opcode, .regs_equal,
      .state,
      .bus_src, .bus_const,
      .ir_we, .pc_we, .rb_we, .rb_sel, .rb_from_mem,
      .ale, .mem_we
   );

   up_datapath i_up_datapath (
      .clk, .nRst, .restart,
      .bus_src, .bus_const,
      .ir_we, .pc_we, .rb_we, .rb_sel, .rb_from_mem, .ale,
      .data_in,
      .data_bus, .addr,
      .opcode, .regs_equal,
      .pc, .ir,
      .r0, .r1, .r2, .r3
   );

   up_memory i_up_memory (
      .clk, .nRst,
      .mem_map_load, .mem_map_address, .mem_map_in,
      .addr, .data_bus, .mem_we,
      .state, .pc, .ir,
      .r0, .r1, .r2, .r3,
      .data_in, .mem_map_out,
      .restart, .halt
   );

endmodule

`default_nettype wire

// ==== verilog/up_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module up_memory
   import up_pkg::*;
(
   input  wire logic                   clk,
   input  wire logic                   nRst,
   input  wire logic                   mem_map_load,
   input  wire logic [host_addr_w-1:0] mem_map_address,
   input  wire logic [data_w-1:0]      mem_map_in,
   input  wire logic [data_w-1:0]      addr,
   input  wire logic [data_w-1:0]      data_bus,
   input  wire logic                   mem_we,
   input  state_t                      state,
   input  wire logic [data_w-1:0]      pc,
   input  wire logic [3:0]             ir,
   input  wire logic [data_w-1:0]      r0,
   input  wire logic [data_w-1:0]      r1,
   input  wire logic [data_w-1:0]      r2,
   input  wire logic [data_w-1:0]      r3,
   output logic      [data_w-1:0]      data_in,
   output logic      [data_w-1:0]      mem_map_out,
   output logic                        restart,
   output logic                        halt
);

   logic [data_w-1:0] mem [mem_depth];
   logic [data_w-1:0] reg_off;
   logic              host_mem_we;
   logic              host_ctrl_we;

   assign reg_off      = mem_map_address[data_w-1:0];
   assign host_mem_we  = mem_map_load & ~mem_map_address[host_addr_w-1];
   assign host_ctrl_we = mem_map_load & (mem_map_address == host_ctrl_addr);
   assign data_in      = mem[addr];

   always_ff @(posedge clk) begin
      if (host_mem_we) begin
         mem[reg_off] <= mem_map_in;                            // Host beats core store
      end else if (mem_we) begin
         mem[addr] <= data_bus;
      end
   end

   // Run control, one cycle pulses to the core
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         restart <= 1'b0;
         halt    <= 1'b0;
      end else begin
         restart <= host_ctrl_we & mem_map_in[0];
         halt    <= host_ctrl_we & ~mem_map_in[0];
      end
   end

   always_comb begin
      if (mem_map_address[host_addr_w-1]) begin
         case (reg_off)
            host_state_addr:          mem_map_out = data_w'(state);
            host_ir_addr:             mem_map_out = data_w'(ir);
            host_pc_addr:             mem_map_out = pc;
            host_r0_addr:             mem_map_out = r0;
            host_r0_addr + 8'd1:      mem_map_out = r1;
            host_r0_addr + 8'd2:      mem_map_out = r2;
            host_r0_addr + 8'd3:      mem_map_out = r3;
            default:                  mem_map_out = '0;         // Unmapped
         endcase
      end else begin
         mem_map_out = mem[reg_off];
      end
   end

endmodule

`default_nettype wire

// ==== verilog/up_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module up_datapath
   import up_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              nRst,
   input  wire logic              restart,
   input  bus_src_t               bus_src,
   input  wire logic [data_w-1:0] bus_const,
   input  wire logic              ir_we,
   input  wire logic              pc_we,
   input  wire logic              rb_we,
   input  reg_sel_t               rb_sel,
   input  wire logic              rb_from_mem,
   input  wire logic              ale,
   input  wire logic [data_w-1:0] data_in,
   output logic      [data_w-1:0] data_bus,
   output logic      [data_w-1:0] addr,
   output opcode_t                opcode,
   output logic                   regs_equal,
   output logic      [data_w-1:0] pc,
   output logic      [3:0]        ir,
   output logic      [data_w-1:0] r0,
   output logic      [data_w-1:0] r1,
   output logic      [data_w-1:0] r2,
   output logic      [data_w-1:0] r3
);

   logic [data_w-1:0] product;
   logic [data_w-1:0] rb_data;

   assign product    = r1 * r2;
   assign regs_equal = (r1 == r2);                              // Branch condition
   assign opcode     = opcode_t'(ir);
   assign rb_data    = rb_from_mem ? data_in : data_bus;

   always_comb begin
      case (bus_src)
         src_const:   data_bus = bus_const;
         src_byte_pc: data_bus = {1'b0, pc[data_w-1:1]};       // Nibble to byte address
         src_pc_inc:  data_bus = pc + data_w'(1);
         src_add:     data_bus = r1 + r2;
         src_sub:     data_bus = r1 - r2;
         src_mul:     data_bus = product;                      // Low byte only
         src_nand:    data_bus = ~(r1 & r2);
         src_xor01:   data_bus = r0 ^ r1;
         src_xor12:   data_bus = r1 ^ r2;
         src_xor23:   data_bus = r2 ^ r3;
         src_r2:      data_bus = r2;
         src_r3:      data_bus = r3;
         src_mem:     data_bus = data_in;
         default:     data_bus = '0;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc   <= pc_reset;
         ir   <= op_add;
         addr <= '0;
      end else if (restart) begin
         pc   <= pc_reset;
         ir   <= op_add;
         addr <= '0;
      end else begin
         if (pc_we) pc <= data_bus;
         if (ale) addr <= data_bus;
         if (ir_we) begin
            ir <= pc[0] ? data_in[3:0] : data_in[7:4];          // High nibble first
         end
      end
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         r0 <= '0;
         r1 <= '0;
         r2 <= '0;
         r3 <= '0;
      end else if (restart) begin
         r0 <= '0;
         r1 <= '0;
         r2 <= '0;
         r3 <= '0;
      end else if (rb_we) begin
         case (rb_sel)
            reg_r0: r0 <= rb_data;
            reg_r1: r1 <= rb_data;
            reg_r2: r2 <= rb_data;
            reg_r3: r3 <= rb_data;
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/up_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module up_control
   import up_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              nRst,
   input  wire logic              restart,
   input  wire logic              halt,
   input  opcode_t                opcode,
   input  wire logic              regs_equal,
   output state_t                 state,
   output bus_src_t               bus_src,
   output logic      [data_w-1:0] bus_const,
   output logic                   ir_we,
   output logic                   pc_we,
   output logic                   rb_we,
   output reg_sel_t               rb_sel,
   output logic                   rb_from_mem,
   output logic                   ale,
   output logic                   mem_we
);

   state_t state_next;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= st_halt;                                      // Wait for host restart
      end else if (halt) begin
         state <= st_halt;
      end else if (restart) begin
         state <= st_load_0;
      end else begin
         state <= state_next;
      end
   end

   always_comb begin
      state_next = st_fetch;
      case (state)
         st_halt:   state_next = st_halt;
         st_load_0: state_next = st_load_1;
         st_load_1: state_next = st_load_2;
         st_load_2: state_next = st_load_3;
         st_load_3: state_next = st_load_4;
         st_load_4: state_next = st_fetch;
         st_fetch:  state_next = st_decode;
         st_decode: state_next = st_exec_1;
         st_exec_1: begin
            case (opcode)
               op_sw01, op_sw12, op_sw23,
               op_ldw, op_stw, op_ref:   state_next = st_exec_2;
               default:                  state_next = st_fetch;   // Reserved, pc advance only
            endcase
         end
         st_exec_2: begin
            if (opcode inside {op_sw01, op_sw12, op_sw23}) begin
               state_next = st_exec_3;                          // Third XOR step
            end
         end
         st_exec_3: state_next = st_fetch;
         default:   state_next = st_halt;
      endcase
   end

   always_comb begin
      bus_src     = src_const;
      bus_const   = '0;
      ir_we       = 1'b0;
      pc_we       = 1'b0;
      rb_we       = 1'b0;
      rb_sel      = reg_r0;
      rb_from_mem = 1'b0;
      ale         = 1'b0;
      mem_we      = 1'b0;
      case (state)
         st_load_0: ale = 1'b1;                                 // Point at byte 0
         st_load_1: begin
            bus_const   = data_w'(1);
            ale         = 1'b1;
            rb_we       = 1'b1;
            rb_from_mem = 1'b1;
         end
         st_load_2: begin
            bus_const   = data_w'(2);
            ale         = 1'b1;
            rb_we       = 1'b1;
            rb_sel      = reg_r1;
            rb_from_mem = 1'b1;
         end
         st_load_3: begin
            bus_const   = data_w'(3);
            ale         = 1'b1;
            rb_we       = 1'b1;
            rb_sel      = reg_r2;
            rb_from_mem = 1'b1;
         end
         st_load_4: begin
            bus_src     = src_byte_pc;
            ale         = 1'b1;
            rb_we       = 1'b1;
            rb_sel      = reg_r3;
            rb_from_mem = 1'b1;
         end
         st_fetch: begin
            bus_src = src_byte_pc;
            ale     = 1'b1;
         end
         st_decode: begin
            bus_src = src_pc_inc;                               // Next nibble
            ir_we   = 1'b1;
            pc_we   = 1'b1;
         end
         st_exec_1: begin
            case (opcode)
               op_add:  begin bus_src = src_add;  rb_we = 1'b1; end
               op_sub:  begin bus_src = src_sub;  rb_we = 1'b1; end
               op_mul:  begin bus_src = src_mul;  rb_we = 1'b1; end
               op_nand: begin bus_src = src_nand; rb_we = 1'b1; end
               op_sw01: begin bus_src = src_xor01; rb_we = 1'b1; end
               op_sw12: begin bus_src = src_xor12; rb_we = 1'b1; rb_sel = reg_r1; end
               op_sw23: begin bus_src = src_xor23; rb_we = 1'b1; rb_sel = reg_r2; end
               op_be:   begin bus_src = src_r3; pc_we = regs_equal; end
               op_ldw, op_stw: begin bus_src = src_r3; ale = 1'b1; end
               op_ref:  ale = 1'b1;                             // Byte 0
               default: ;
            endcase
         end
         st_exec_2: begin
            case (opcode)
               op_sw01: begin bus_src = src_xor01; rb_we = 1'b1; rb_sel = reg_r1; end
               op_sw12: begin bus_src = src_xor12; rb_we = 1'b1; rb_sel = reg_r2; end
               op_sw23: begin bus_src = src_xor23; rb_we = 1'b1; rb_sel = reg_r3; end
               op_ldw:  begin rb_we = 1'b1; rb_sel = reg_r2; rb_from_mem = 1'b1; end
               op_stw:  begin bus_src = src_r2; mem_we = 1'b1; end
               op_ref:  begin rb_we = 1'b1; rb_from_mem = 1'b1; end
               default: ;
            endcase
         end
         st_exec_3: begin
            case (opcode)
               op_sw01: begin bus_src = src_xor01; rb_we = 1'b1; end
               op_sw12: begin bus_src = src_xor12; rb_we = 1'b1; rb_sel = reg_r1; end
               op_sw23: begin bus_src = src_xor23; rb_we = 1'b1; rb_sel = reg_r2; end
               default: ;
            endcase
         end
         default: ;                                             // Halted, all quiet
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/up_pkg.sv ====
`default_nettype none

package up_pkg;

   localparam int data_w      = 8;
   localparam int mem_depth   = 256;
   localparam int host_addr_w = 9;                              // Bit 8 picks register space

   localparam logic [data_w-1:0]      pc_reset       = 8'h08;  // Byte 4, high nibble
   localparam logic [host_addr_w-1:0] host_ctrl_addr = 9'h100;

   // Readout offsets within the register space
   localparam logic [data_w-1:0] host_state_addr = 8'h00;
   localparam logic [data_w-1:0] host_ir_addr    = 8'h01;
   localparam logic [data_w-1:0] host_pc_addr    = 8'h02;
   localparam logic [data_w-1:0] host_r0_addr    = 8'h03;     // r1 to r3 follow

   typedef enum logic [3:0] {
      st_halt,
      st_load_0,
      st_load_1,
      st_load_2,
      st_load_3,
      st_load_4,
      st_fetch,
      st_decode,
      st_exec_1,
      st_exec_2,
      st_exec_3
   } state_t;

   typedef enum logic [3:0] {
      op_add  = 4'h0, op_sub  = 4'h1, op_mul  = 4'h2, op_nand = 4'h3,
      op_sw01 = 4'h4, op_sw12 = 4'h5, op_sw23 = 4'h6, op_be   = 4'h7,
      op_rsv8 = 4'h8, op_rsv9 = 4'h9, op_rsva = 4'ha, op_rsvb = 4'hb,
      op_ldw  = 4'hc, op_stw  = 4'hd, op_ref  = 4'he, op_rsvf = 4'hf
   } opcode_t;

   typedef enum logic [3:0] {
      src_const,                                                // Constant from control
      src_byte_pc,                                              // Byte holding current nibble
      src_pc_inc,
      src_add,
      src_sub,
      src_mul,
      src_nand,
      src_xor01,
      src_xor12,
      src_xor23,
      src_r2,
      src_r3,
      src_mem
   } bus_src_t;

   typedef enum logic [1:0] {reg_r0, reg_r1, reg_r2, reg_r3} reg_sel_t;

endpackage

`default_nettype wire
